// ==== src.f ====
hw/frame_pkg.sv
hw/frame_sequencer.sv
hw/frame_item_counter.sv
hw/frame_assembler.sv
hw/uart_tx.sv
hw/game_frame_sender.sv
testbench/tb_clock_gen.sv
testbench/tb_game_frame_sender.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the game frame sender testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_game_frame_sender \
        -f src.f --Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
        cat build.log
        echo "verilator build failed"
        exit 1
fi

./obj_dir/sim_tb > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -qF "*** TEST FAILED ***" "$log_file"; then
        exit 1
fi
if [ $sim_status -ne 0 ] || ! grep -qF "*** TEST PASSED ***" "$log_file"; then
        echo "simulation ended abnormally"
        exit 1
fi
exit 0

// ==== testbench/tb_game_frame_sender.sv ====
`timescale 1ns/1ps

module tb_game_frame_sender
        import frame_pkg::*;
();

        localparam int CLKS_PER_BIT   = 4;
        localparam int NUM_FOOTER     = 2;
        localparam int FRAME_BYTES    = 1 + NUM_ASTEROIDS + NUM_SHOTS + NUM_FOOTER;
        localparam int TIMEOUT_CYCLES = 6000; // ~8 frames of 9 bytes at 43 cycles, with margin

        logic        clock;
        logic        reset;
        logic        send_frame;
        game_state_t game_state;
        logic        serial;
        logic        busy;
        logic        frame_done;

        byte_t expected_bytes [FRAME_BYTES];
        int    error_count = 0;
        int    cycle_count = 0;
        int    done_count  = 0;

        tb_clock_gen #(.PERIOD_NS(100)) i_tb_clock_gen (.clock);

        game_frame_sender #(
                .CLKS_PER_BIT(CLKS_PER_BIT),
                .NUM_FOOTER(NUM_FOOTER)
        ) i_game_frame_sender (
                .clock, .reset, .send_frame, .game_state, .serial, .busy, .frame_done
        );

        always @(posedge clock) begin
                cycle_count <= cycle_count + 1;
                if (!reset && frame_done) begin
                        done_count <= done_count + 1;
                end
                if (cycle_count >= TIMEOUT_CYCLES) begin
                        stop_on_failure("timeout, the DUT did not finish the frames in time");
                end
        end

        task automatic stop_on_failure(input string reason);
                $display("%s", reason);
                $display("*** TEST FAILED ***");
                $fatal(1, "simulation stopped");
        endtask

        task automatic check_value(input string test_name, input logic [31:0] expected,
                                   input logic [31:0] actual);
                if (expected !== actual) begin
                        error_count++;
                        stop_on_failure($sformatf("[ERROR] %s: expected %0h, actual %0h",
                                                  test_name, expected, actual));
                end
        endtask

        // frame rule: score, asteroids, shots, then the footer bytes; x in the high nibble
        task automatic build_expected(input game_state_t state);
                int i;
                expected_bytes[0] = state.score;
                for (i = 0; i < NUM_ASTEROIDS; i++) begin
                        expected_bytes[1 + i] = {state.asteroids[i].x, state.asteroids[i].y};
                end
                for (i = 0; i < NUM_SHOTS; i++) begin
                        expected_bytes[1 + NUM_ASTEROIDS + i] = {state.shots[i].x, state.shots[i].y};
                end
                for (i = 0; i < NUM_FOOTER; i++) begin
                        expected_bytes[1 + NUM_ASTEROIDS + NUM_SHOTS + i] = FOOTER_BYTE;
                end
        endtask

        function automatic game_state_t random_state();
                game_state_t state;
                int          i;
                state.score = 8'($urandom);
                for (i = 0; i < NUM_ASTEROIDS; i++) begin
                        state.asteroids[i] = position_t'(8'($urandom));
                end
                for (i = 0; i < NUM_SHOTS; i++) begin
                        state.shots[i] = position_t'(8'($urandom));
                end
                return state;
        endfunction

        // samples each bit in the middle of its period, returns at mid stop bit
        task automatic receive_byte(input string test_name, output byte_t value);
                int bit_index;
                @(negedge clock);
                while (serial !== 1'b0) begin
                        @(negedge clock);
                end
                repeat (CLKS_PER_BIT / 2) @(negedge clock);
                if (serial !== 1'b0) begin
                        stop_on_failure("start bit ended before the middle of its period");
                end
                for (bit_index = 0; bit_index < 8; bit_index++) begin
                        repeat (CLKS_PER_BIT) @(negedge clock);
                        value[bit_index] = serial;
                        check_value(test_name, 32'd1, 32'(busy));
                end
                repeat (CLKS_PER_BIT) @(negedge clock);
                if (serial !== 1'b1) begin
                        stop_on_failure("stop bit was sampled low");
                end
        endtask

        task automatic wait_frame_done();
                @(negedge clock);
                while (frame_done !== 1'b1) begin
                        @(negedge clock);
                end
        endtask

        task automatic request_frame(input string test_name, input game_state_t state);
                game_state = state;
                send_frame = 1'b1;
                @(negedge clock);
                send_frame = 1'b0;
                check_value(test_name, 32'd1, 32'(busy)); // request taken
        endtask

        // poke_after >= 0 pulses send_frame once that byte has been received
        task automatic collect_frame(input string test_name, input int poke_after);
                byte_t received;
                int    done_before;
                int    i;
                done_before = done_count;
                for (i = 0; i < FRAME_BYTES; i++) begin
                        receive_byte(test_name, received);
                        check_value(test_name, 32'(expected_bytes[i]), 32'(received));
                        if (i == poke_after) begin
                                send_frame = 1'b1;
                                @(negedge clock);
                                send_frame = 1'b0;
                        end
                end
                check_value(test_name, 32'(done_before), 32'(done_count)); // no early pulse
                wait_frame_done();
                @(negedge clock);
                check_value(test_name, 32'(done_before + 1), 32'(done_count));
                check_value(test_name, 32'd0, 32'(busy));
        endtask

        task automatic test_reset_state();
                repeat (20) begin
                        @(negedge clock);
                        check_value("reset_state", 32'd1, 32'(serial));
                        check_value("reset_state", 32'd0, 32'(busy));
                        check_value("reset_state", 32'd0, 32'(frame_done));
                end
        endtask

        task automatic test_single_frame();
                game_state_t state;
                state.score        = 8'h5c;
                state.asteroids[0] = position_t'(8'h12);
                state.asteroids[1] = position_t'(8'h34);
                state.asteroids[2] = position_t'(8'h56);
                state.asteroids[3] = position_t'(8'h78);
                state.shots[0]     = position_t'(8'h9a);
                state.shots[1]     = position_t'(8'hbc);
                build_expected(state);
                request_frame("single_frame", state);
                collect_frame("single_frame", -1);
        endtask

        task automatic test_snapshot();
                game_state_t state;
                state = random_state();
                build_expected(state);
                request_frame("snapshot", state);
                @(negedge clock);
                game_state = game_state_t'(~state); // capture sampled the old value at this edge
                collect_frame("snapshot", -1);
        endtask

        task automatic test_request_while_busy();
                int done_before;
                build_expected(game_state);
                request_frame("request_while_busy", game_state);
                collect_frame("request_while_busy", 3);
                done_before = done_count;
                repeat (60) begin
                        @(negedge clock);
                        check_value("request_while_busy", 32'd1, 32'(serial));
                        check_value("request_while_busy", 32'd0, 32'(busy));
                end
                check_value("request_while_busy", 32'(done_before), 32'(done_count));
        endtask

        task automatic test_random_frames();
                game_state_t state;
                int          frame;
                for (frame = 0; frame < 5; frame++) begin
                        state = random_state();
                        build_expected(state);
                        request_frame($sformatf("random_frames[%0d]", frame), state);
                        collect_frame($sformatf("random_frames[%0d]", frame), -1);
                end
        endtask

        initial begin
                void'($urandom(78));
                reset      = 1'b1;
                send_frame = 1'b0;
                game_state = '0;
                repeat (3) @(posedge clock);
                @(negedge clock);
                reset = 1'b0;
                test_reset_state();
                test_single_frame();
                test_snapshot();
                test_request_while_busy();
                test_random_frames();
                if (error_count == 0) begin
                        $display("*** TEST PASSED ***");
                end else begin
                        $display("*** TEST FAILED ***");
                end
                $finish;
        end

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
        parameter int PERIOD_NS = 100
) (
        output logic clock
);

        initial begin
                clock = 1'b0;
        end

        always #(PERIOD_NS / 2) clock = ~clock;

endmodule

// ==== hw/game_frame_sender.sv ====
`timescale 1ns/1ps

module game_frame_sender
        import frame_pkg::*;
#(
        parameter int CLKS_PER_BIT = 4,
        parameter int NUM_FOOTER   = 2
) (
        input  logic        clock,
        input  logic        reset,
        input  logic        send_frame,
        input  game_state_t game_state,
        output logic        serial,
        output logic        busy,
        output logic        frame_done
);

        section_e               section;
        logic                   clear;
        logic                   advance;
        logic                   capture;
        logic                   tx_start;
        logic                   tx_done;
        logic                   last;
        logic [INDEX_WIDTH-1:0] index;
        byte_t                  tx_byte;

        frame_sequencer i_frame_sequencer (
                .clock, .reset, .send_frame, .tx_done, .last,
                .section, .clear, .advance, .capture, .tx_start, .busy, .frame_done
        );

        frame_item_counter #(
                .NUM_FOOTER(NUM_FOOTER)
        ) i_frame_item_counter (
                .clock, .reset, .section, .clear, .advance, .index, .last
        );

        frame_assembler i_frame_assembler (
                .clock, .reset, .capture, .game_state, .section, .index, .tx_byte
        );

        uart_tx #(
                .CLKS_PER_BIT(CLKS_PER_BIT)
        ) i_uart_tx (
                .clock, .reset, .tx_start, .tx_byte, .serial, .tx_done
        );

endmodule

// ==== hw/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx
        import frame_pkg::*;
#(
        parameter int CLKS_PER_BIT = 4
) (
        input  logic  clock,
        input  logic  reset,
        input  logic  tx_start,
        input  byte_t tx_byte,
        output logic  serial,
        output logic  tx_done
);

        localparam int TIMER_WIDTH = $clog2(CLKS_PER_BIT + 1);
        localparam logic [TIMER_WIDTH-1:0] TIMER_LAST = TIMER_WIDTH'(CLKS_PER_BIT - 1);

        logic                   active;
        logic [9:0]             shifter;   // stop, data, start
        logic [TIMER_WIDTH-1:0] timer;
        logic [3:0]             bit_count;
        logic                   bit_end;

        assign bit_end = (timer == TIMER_LAST);

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        active    <= 1'b0;
                        timer     <= '0;
                        bit_count <= '0;
                        tx_done   <= 1'b0;
                end else begin
                        tx_done <= 1'b0;
                        if (!active) begin
                                if (tx_start) begin
                                        active    <= 1'b1;
                                        timer     <= '0;
                                        bit_count <= '0;
                                end
                        end else if (bit_end) begin
                                timer     <= '0;
                                bit_count <= bit_count + 1'b1;
                                if (bit_count == 4'd9) begin // stop bit finished
                                        active  <= 1'b0;
                                        tx_done <= 1'b1;
                                end
                        end else begin
                                timer <= timer + 1'b1;
                        end
                end
        end

        always_ff @(posedge clock) begin
                if (!active && tx_start) begin
                        shifter <= {1'b1, tx_byte, 1'b0};
                end else if (active && bit_end) begin
                        shifter <= {1'b1, shifter[9:1]}; // lsb first
                end
        end

        assign serial = active ? shifter[0] : 1'b1;

        assert property (@(posedge clock) disable iff (reset) tx_start |-> !active)
                else $error("tx_start during a transmission");

endmodule

// ==== hw/frame_assembler.sv ====
`timescale 1ns/1ps

module frame_assembler
        import frame_pkg::*;
(
        input  logic                   clock,
        input  logic                   reset,
        input  logic                   capture,
        input  game_state_t            game_state,
        input  section_e               section,
        input  logic [INDEX_WIDTH-1:0] index,
        output byte_t                  tx_byte
);

        game_state_t snapshot;

        // frozen for the whole frame, later game_state changes wait for the next one
        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        snapshot <= '0;
                end else if (capture) begin
                        snapshot <= game_state;
                end
        end

        always_comb begin
                case (section)
                        SEC_SCORE: begin
                                tx_byte = snapshot.score;
                        end
                        SEC_ASTEROID: begin
                                tx_byte = byte_t'(snapshot.asteroids[index]);
                        end
                        SEC_SHOT: begin
                                tx_byte = byte_t'(snapshot.shots[index]);
                        end
                        default: begin
                                tx_byte = FOOTER_BYTE;
                        end
                endcase
        end

        // index stays inside the array of the section being read
        assert property (@(posedge clock) disable iff (reset)
                (section == SEC_SHOT) |-> (index < INDEX_WIDTH'(NUM_SHOTS)))
                else $error("shot index out of range");

endmodule

// ==== hw/frame_item_counter.sv ====
`timescale 1ns/1ps

module frame_item_counter
        import frame_pkg::*;
#(
        parameter int NUM_FOOTER = 2
) (
        input  logic                   clock,
        input  logic                   reset,
        input  section_e               section,
        input  logic                   clear,
        input  logic                   advance,
        output logic [INDEX_WIDTH-1:0] index,
        output logic                   last
);

        logic [INDEX_WIDTH-1:0] last_index;

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        index <= '0;
                end else if (clear) begin
                        index <= '0;
                end else if (advance) begin
                        index <= index + 1'b1;
                end
        end

        // item count of the current section, minus one
        always_comb begin
                case (section)
                        SEC_SCORE:    last_index = '0;
                        SEC_ASTEROID: last_index = INDEX_WIDTH'(NUM_ASTEROIDS - 1);
                        SEC_SHOT:     last_index = INDEX_WIDTH'(NUM_SHOTS - 1);
                        default:      last_index = INDEX_WIDTH'(NUM_FOOTER - 1);
                endcase
        end

        assign last = (index == last_index);

        // the sequencer has to switch section instead of stepping past the end
        assert property (@(posedge clock) disable iff (reset) !(advance && last))
                else $error("advance past the last item of a section");

endmodule

// ==== hw/frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer
        import frame_pkg::*;
(
        input  logic     clock,
        input  logic     reset,
        input  logic     send_frame,
        input  logic     tx_done,
        input  logic     last,
        output section_e section,
        output logic     clear,
        output logic     advance,
        output logic     capture,
        output logic     tx_start,
        output logic     busy,
        output logic     frame_done
);

        sequencer_state_e state, next_state;
        logic             section_end; // last item of a section other than the footer

        assign section_end = (state == ST_STEP) && last && (section != SEC_FOOTER);

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        state <= ST_IDLE;
                end else begin
                        state <= next_state;
                end
        end

        always_comb begin
                next_state = state;
                case (state)
                        ST_IDLE:    next_state = send_frame ? ST_CAPTURE : ST_IDLE;
                        ST_CAPTURE: next_state = ST_START;
                        ST_START:   next_state = ST_WAIT;
                        ST_WAIT:    next_state = tx_done ? ST_STEP : ST_WAIT;
                        ST_STEP: begin
                                if (last && section == SEC_FOOTER) begin
                                        next_state = ST_DONE;
                                end else begin
                                        next_state = ST_START;
                                end
                        end
                        ST_DONE:    next_state = ST_IDLE;
                        default:    next_state = ST_IDLE;
                endcase
        end

        // section register steps on after the last item of each section
        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        section <= SEC_SCORE;
                end else if (state == ST_CAPTURE) begin
                        section <= SEC_SCORE;
                end else if (section_end) begin
                        case (section)
                                SEC_SCORE:    section <= SEC_ASTEROID;
                                SEC_ASTEROID: section <= SEC_SHOT;
                                default:      section <= SEC_FOOTER;
                        endcase
                end
        end

        always_comb begin
                capture    = (state == ST_CAPTURE);
                tx_start   = (state == ST_START);
                busy       = (state != ST_IDLE);
                frame_done = (state == ST_DONE);
                advance    = (state == ST_STEP) && !last;
                clear      = (state == ST_CAPTURE) || section_end;
        end

        // snapshot must be settled before the first byte is latched
        assert property (@(posedge clock) disable iff (reset) !(tx_start && capture))
                else $error("tx_start and capture asserted together");

endmodule

// ==== hw/frame_pkg.sv ====
package frame_pkg;

        typedef logic [7:0] byte_t;

        // one position per byte, x in the high nibble
        typedef struct packed {
                logic [3:0] x;
                logic [3:0] y;
        } position_t;

        localparam int NUM_ASTEROIDS = 4;
        localparam int NUM_SHOTS     = 2;

        typedef struct packed {
                byte_t                         score;
                position_t [NUM_ASTEROIDS-1:0] asteroids;
                position_t [NUM_SHOTS-1:0]     shots;
        } game_state_t; // 56 bits

        localparam byte_t FOOTER_BYTE = 8'h0A;

        localparam int INDEX_WIDTH = 3;

        // order matters, the sequencer steps through these in sequence
        typedef enum logic [1:0] {
                SEC_SCORE, SEC_ASTEROID, SEC_SHOT, SEC_FOOTER
        } section_e;

        typedef enum logic [2:0] {
                ST_IDLE, ST_CAPTURE, ST_START, ST_WAIT, ST_STEP, ST_DONE
        } sequencer_state_e;

endpackage
